//--- source/ooo_pkg.sv
// shared widths, ALU functions and the two instruction-word layouts
// no register renaming: the program must not reuse a destination still in flight
package ooo_pkg;

    // reservation station geometry
    localparam int iq_entries = 4;       // entries in the issue queue
    localparam int iq_idx_width = 2;     // entry index and age width
    // architectural register file
    localparam int reg_addr_width = 5;
    localparam int reg_num = 32;         // register 0 reads zero and is always ready
    localparam int data_width = 32;
    localparam int imm_width = 18;       // immediate field, sign-extended to data_width

    // ALU functions, encoded in 3 bits of the instruction word
    typedef enum logic [2:0] {
        alu_add = 3'd0,
        alu_sub = 3'd1,
        alu_and = 3'd2,
        alu_or  = 3'd3,
        alu_xor = 3'd4,
        alu_sll = 3'd5,  // shift amount is the low 5 bits of operand b
        alu_srl = 3'd6,  // logical shift, zero fill
        alu_slt = 3'd7   // signed compare, result is 0 or 1
    } alu_func_e;

    // register form, selected when the flag in bit 31 is low
    typedef struct packed {
        logic                      is_imm;  // form flag, shared by both layouts
        alu_func_e                 func;
        logic [reg_addr_width-1:0] dst;
        logic [reg_addr_width-1:0] src1;
        logic [reg_addr_width-1:0] src2;
        logic [12:0]               pad;     // unused in register form
    } reg_form_t;

    // immediate form, selected when the flag is high
    // the flag, func, dst and src1 sit at the same bits as in register form
    typedef struct packed {
        logic                      is_imm;
        alu_func_e                 func;
        logic [reg_addr_width-1:0] dst;
        logic [reg_addr_width-1:0] src1;
        logic [imm_width-1:0]      imm;     // replaces src2 and the pad bits
    } imm_form_t;

    // one 32-bit word read through either layout
    // both members are 32 bits wide so they overlay exactly
    typedef union packed {
        reg_form_t r;
        imm_form_t i;
    } insn_word_u;

    // flag value that marks an immediate-form word
    localparam logic form_imm = 1'b1;

endpackage

//--- source/insn_decoder.sv
// one-word skid buffer in front of the issue queue, decodes both word forms on capture
// immediate form sends src2 as register 0 so the queue treats it as always ready
`timescale 1ns/1ps

module insn_decoder import ooo_pkg::*; (
    input  logic                      clk,
    input  logic                      reset,
    // word port from outside
    input  logic                      in_valid,
    input  insn_word_u                in_word,
    output logic                      in_ready,
    // load port into the issue queue
    input  logic                      is_full,
    output logic                      load,
    output alu_func_e                 func,
    output logic [reg_addr_width-1:0] src1,
    output logic [reg_addr_width-1:0] src2,
    output logic [reg_addr_width-1:0] dst,
    output logic                      use_imm,
    output logic [data_width-1:0]     imm
);

    logic buf_full;  // decoded fields below hold a word waiting for the queue
    logic accept;    // word handshake completes on this edge

    // the buffer drains into the queue whenever the queue has room
    assign load = buf_full && !is_full;

    // the buffer can take a new word when empty, or when its word leaves this cycle
    assign in_ready = !buf_full || load;

    assign accept = in_valid && in_ready;

    // buffer state, only control needs a reset
    always_ff @(posedge clk) begin
        if (reset) begin
            buf_full <= 1'b0;
        end else if (accept) begin
            buf_full <= 1'b1;     // a simultaneous load is replaced by the new word
        end else if (load) begin
            buf_full <= 1'b0;     // queue took the word, nothing behind it
        end
    end

    // decode on capture, fields are registered so the queue sees stable values
    always_ff @(posedge clk) begin
        if (accept) begin
            func <= in_word.r.func;  // same bits in both layouts
            dst  <= in_word.r.dst;
            src1 <= in_word.r.src1;
            if (in_word.r.is_imm == form_imm) begin
                use_imm <= 1'b1;
                src2    <= '0;      // register 0 is always ready in the table
                // sign-extend the 18-bit field to a full operand
                imm     <= {{(data_width - imm_width){in_word.i.imm[imm_width-1]}},
                            in_word.i.imm};
            end else begin
                use_imm <= 1'b0;
                src2    <= in_word.r.src2;
                imm     <= '0;      // operand b comes from the register file
            end
        end
    end

endmodule

//--- source/issue_queue.sv
// four-entry reservation station, issues the oldest entry whose sources are ready
// wakeup assumes a one-cycle producer, so the destination is marked ready on selection
`timescale 1ns/1ps

module issue_queue import ooo_pkg::*; (
    input  logic                      clk,
    input  logic                      reset,
    // load port from the decoder
    input  logic                      load,
    input  alu_func_e                 func,
    input  logic [reg_addr_width-1:0] src1,
    input  logic [reg_addr_width-1:0] src2,
    input  logic [reg_addr_width-1:0] dst,
    input  logic                      use_imm,
    input  logic [data_width-1:0]     imm,
    output logic                      is_full,
    // issue register towards the execute stage
    input  logic                      iss_ready,
    output logic                      iss_valid,
    output alu_func_e                 iss_func,
    output logic [reg_addr_width-1:0] iss_src1,
    output logic [reg_addr_width-1:0] iss_src2,
    output logic [reg_addr_width-1:0] iss_dst,
    output logic                      iss_use_imm,
    output logic [data_width-1:0]     iss_imm
);

    // per-entry control state
    logic [iq_entries-1:0]   e_valid;
    logic [iq_entries-1:0]   e_ready1;             // src1 result available
    logic [iq_entries-1:0]   e_ready2;             // src2 result available
    logic [iq_idx_width-1:0] e_age [iq_entries];   // 0 is the oldest entry

    // per-entry payload, written on load only
    alu_func_e                 e_func    [iq_entries];
    logic [reg_addr_width-1:0] e_src1    [iq_entries];
    logic [reg_addr_width-1:0] e_src2    [iq_entries];
    logic [reg_addr_width-1:0] e_dst     [iq_entries];
    logic                      e_use_imm [iq_entries];
    logic [data_width-1:0]     e_imm     [iq_entries];

    logic [reg_num-1:0] ready_tbl;  // a low bit means a result is still pending
    logic [reg_num-1:0] rt_woke;    // table with this cycle's wakeup applied

    logic [iq_idx_width:0]   occ;       // valid entries, 0 to 4
    logic [iq_idx_width:0]   stay_cnt;  // entries left after this cycle's issue
    logic [iq_entries-1:0]   req;       // valid with both sources ready
    logic                    iss_free;  // issue register empty or being taken
    logic                    sel_found;
    logic [iq_idx_width-1:0] sel_idx;
    logic [iq_idx_width-1:0] sel_age;
    logic                    do_sel;
    logic [reg_addr_width-1:0] wake_dst;
    logic [iq_idx_width-1:0] free_idx;  // lowest invalid slot

    always_comb begin
        occ = '0;
        for (int i = 0; i < iq_entries; i++) begin
            occ = occ + {{iq_idx_width{1'b0}}, e_valid[i]};
        end
    end

    assign is_full = (occ == (iq_idx_width + 1)'(iq_entries));
    assign req = e_valid & e_ready1 & e_ready2;
    assign iss_free = !iss_valid || iss_ready;

    // oldest ready entry, ages of valid entries are unique
    always_comb begin
        sel_found = 1'b0;
        sel_idx   = '0;
        sel_age   = '1;
        for (int i = 0; i < iq_entries; i++) begin
            if (req[i] && (!sel_found || e_age[i] < sel_age)) begin
                sel_found = 1'b1;
                sel_idx   = iq_idx_width'(i);
                sel_age   = e_age[i];
            end
        end
    end

    assign do_sel   = iss_free && sel_found;  // selection and wakeup share this edge
    assign wake_dst = e_dst[sel_idx];

    // scan downwards so the lowest free slot wins
    always_comb begin
        free_idx = '0;
        for (int i = iq_entries - 1; i >= 0; i--) begin
            if (!e_valid[i]) begin
                free_idx = iq_idx_width'(i);
            end
        end
    end

    // a load in the same cycle sees the wakeup through this bypass
    always_comb begin
        rt_woke = ready_tbl;
        if (do_sel) begin
            rt_woke[wake_dst] = 1'b1;
        end
    end

    // the new entry is younger than every entry that stays
    assign stay_cnt = occ - {{iq_idx_width{1'b0}}, do_sel};

    always_ff @(posedge clk) begin
        if (reset) begin
            ready_tbl <= '1;   // nothing in flight after reset
        end else begin
            ready_tbl <= rt_woke;
            if (load && dst != '0) begin
                ready_tbl[dst] <= 1'b0;  // register 0 never goes pending
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            e_valid  <= '0;
            e_ready1 <= '0;
            e_ready2 <= '0;
            for (int i = 0; i < iq_entries; i++) begin
                e_age[i] <= '0;
            end
        end else begin
            if (do_sel) begin
                for (int i = 0; i < iq_entries; i++) begin
                    if (e_valid[i]) begin
                        // wake both sources, an entry may read the same register twice
                        if (e_src1[i] == wake_dst) e_ready1[i] <= 1'b1;
                        if (e_src2[i] == wake_dst) e_ready2[i] <= 1'b1;
                        if (e_age[i] > sel_age) e_age[i] <= e_age[i] - 1'b1;
                    end
                end
                e_valid[sel_idx] <= 1'b0;
            end
            // the load slot is free now, so these writes never collide with the loop above
            if (load) begin
                e_valid[free_idx]  <= 1'b1;
                e_ready1[free_idx] <= rt_woke[src1];
                e_ready2[free_idx] <= rt_woke[src2];
                e_age[free_idx]    <= stay_cnt[iq_idx_width-1:0];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            e_func[free_idx]    <= func;
            e_src1[free_idx]    <= src1;
            e_src2[free_idx]    <= src2;
            e_dst[free_idx]     <= dst;
            e_use_imm[free_idx] <= use_imm;
            e_imm[free_idx]     <= imm;
        end
    end

    // issue register, frozen while the execute stage is stalled
    always_ff @(posedge clk) begin
        if (reset) begin
            iss_valid <= 1'b0;
        end else if (iss_free) begin
            iss_valid <= sel_found;
        end
    end

    always_ff @(posedge clk) begin
        if (do_sel) begin
            iss_func    <= e_func[sel_idx];
            iss_src1    <= e_src1[sel_idx];
            iss_src2    <= e_src2[sel_idx];
            iss_dst     <= wake_dst;
            iss_use_imm <= e_use_imm[sel_idx];
            iss_imm     <= e_imm[sel_idx];
        end
    end

endmodule

//--- source/execute_stage.sv
// single-cycle ALU with register file read, writeback and a held result register
// no bypass: a dependent instruction is read one edge after its producer writes back
`timescale 1ns/1ps

module execute_stage import ooo_pkg::*; (
    input  logic                      clk,
    input  logic                      reset,
    // instruction from the issue register
    input  logic                      iss_valid,
    input  alu_func_e                 iss_func,
    input  logic [reg_addr_width-1:0] iss_src1,
    input  logic [reg_addr_width-1:0] iss_src2,
    input  logic [reg_addr_width-1:0] iss_dst,
    input  logic                      iss_use_imm,
    input  logic [data_width-1:0]     iss_imm,
    output logic                      iss_ready,
    // result port
    input  logic                      out_ready,
    output logic                      out_valid,
    output logic [reg_addr_width-1:0] out_dst,
    output logic [data_width-1:0]     out_value
);

    logic [data_width-1:0] rf [reg_num];  // architectural registers, entry 0 stays zero

    logic                  take;     // instruction accepted on this edge
    logic [data_width-1:0] op_a;
    logic [data_width-1:0] op_b;
    logic [data_width-1:0] alu_res;

    // a held result blocks the stage until the consumer takes it
    assign iss_ready = !out_valid || out_ready;
    assign take = iss_valid && iss_ready;

    assign op_a = rf[iss_src1];
    assign op_b = iss_use_imm ? iss_imm : rf[iss_src2];  // immediate already sign-extended

    always_comb begin
        case (iss_func)
            alu_add: alu_res = op_a + op_b;
            alu_sub: alu_res = op_a - op_b;
            alu_and: alu_res = op_a & op_b;
            alu_or:  alu_res = op_a | op_b;
            alu_xor: alu_res = op_a ^ op_b;
            // shifts use the low five bits of operand b
            alu_sll: alu_res = op_a << op_b[4:0];
            alu_srl: alu_res = op_a >> op_b[4:0];
            alu_slt: alu_res = {{(data_width - 1){1'b0}}, $signed(op_a) < $signed(op_b)};
            default: alu_res = '0;
        endcase
    end

    // writeback lands on the take edge, so the next reader sees the new value
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < reg_num; i++) begin
                rf[i] <= '0;
            end
        end else if (take && iss_dst != '0) begin
            rf[iss_dst] <= alu_res;  // writes to register 0 are dropped
        end
    end

    // result valid flag
    always_ff @(posedge clk) begin
        if (reset) begin
            out_valid <= 1'b0;
        end else if (take) begin
            out_valid <= 1'b1;
        end else if (out_ready) begin
            out_valid <= 1'b0;   // result consumed and nothing new behind it
        end
    end

    // result payload, held while out_ready is low
    always_ff @(posedge clk) begin
        if (take) begin
            out_dst   <= iss_dst;
            out_value <= alu_res;
        end
    end

endmodule

//--- source/ooo_alu_top.sv
// decoder, reservation station and execute stage in one pipeline
// the program must keep at most seven instructions in flight without destination reuse
`timescale 1ns/1ps

module ooo_alu_top import ooo_pkg::*; (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      in_valid,
    input  insn_word_u                in_word,
    output logic                      in_ready,
    input  logic                      out_ready,
    output logic                      out_valid,
    output logic [reg_addr_width-1:0] out_dst,
    output logic [data_width-1:0]     out_value
);

    // decoder to queue
    logic                      load;
    logic                      is_full;
    alu_func_e                 func;
    logic [reg_addr_width-1:0] src1;
    logic [reg_addr_width-1:0] src2;
    logic [reg_addr_width-1:0] dst;
    logic                      use_imm;
    logic [data_width-1:0]     imm;

    // queue to execute stage
    logic                      iss_valid;
    logic                      iss_ready;
    alu_func_e                 iss_func;
    logic [reg_addr_width-1:0] iss_src1;
    logic [reg_addr_width-1:0] iss_src2;
    logic [reg_addr_width-1:0] iss_dst;
    logic                      iss_use_imm;
    logic [data_width-1:0]     iss_imm;

    insn_decoder i_decoder (.*);   // names match the queue load port one to one

    issue_queue i_queue (.*);

    execute_stage i_execute (.*);  // result port goes straight to the outside

endmodule

//--- tests/ooo_alu_properties.sv
// handshake and occupancy checks, bound into the issue queue and the execute stage
// each binding ties the inputs its module lacks to idle values
`timescale 1ns/1ps

module ooo_alu_properties import ooo_pkg::*; (
    input logic                      clk,
    input logic                      reset,
    input logic                      load,
    input logic                      is_full,
    input logic                      iss_valid,
    input logic                      out_valid,
    input logic                      out_ready,
    input logic [reg_addr_width-1:0] out_dst
);

    // a held result keeps its destination until the consumer takes it
    out_hold: assert property (@(posedge clk) disable iff (reset)
        out_valid && !out_ready |=> out_valid && $stable(out_dst))
        else $error("result changed while out_ready was low");

    // the decoder keeps its word while every queue entry is taken
    no_load_full: assert property (@(posedge clk) disable iff (reset) !(load && is_full))
        else $error("load while the queue is full");

    // the queue leaves reset empty, so nothing issues in the first cycle after it
    iss_reset: assert property (@(posedge clk) $fell(reset) |=> !iss_valid)
        else $error("iss_valid high after reset");

endmodule

bind issue_queue ooo_alu_properties i_queue_props (
    .clk, .reset, .load, .iss_valid,
    .is_full(&e_valid),   // full as seen by the entries themselves
    .out_valid(1'b0), .out_ready(1'b1), .out_dst('0)
);

bind execute_stage ooo_alu_properties i_execute_props (
    .clk, .reset, .iss_valid, .out_valid, .out_ready, .out_dst,
    .load(1'b0), .is_full(1'b0)
);

//--- tests/ooo_alu_tb.sv
// random instruction streams checked against an in-order register model of the cluster
// every stream rotates destinations over registers 1 to 31, so no destination is reused in flight
`timescale 1ns/1ps

module ooo_alu_tb import ooo_pkg::*; ();

    logic                      clk;
    logic                      reset;
    logic                      in_valid;
    insn_word_u                in_word;
    logic                      in_ready;
    logic                      out_ready;
    logic                      out_valid;
    logic [reg_addr_width-1:0] out_dst;
    logic [data_width-1:0]     out_value;

    logic [data_width-1:0] model_rf [reg_num];  // architectural state in program order
    logic [data_width-1:0] exp_val  [reg_num];  // expected result per destination
    logic                  exp_pend [reg_num];  // a result for this register is still owed

    logic [31:0] rng;          // generator state
    int          errors;
    int          sent;         // words accepted in the current test
    int          received;     // results taken in the current test
    int          made;         // words presented in the current test
    int          word_limit;
    int          prog_n;       // program index of the next word, runs across tests
    int          cycles;
    int          cycle_limit;
    bit          taken;        // the presented word is accepted on the coming rising edge

    ooo_alu_top i_dut (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // the upper half of the state is the better random source
    function automatic int unsigned rand_range(input int unsigned n);
        rng = rng * 32'd1664525 + 32'd1013904223;
        return (rng >> 16) % n;
    endfunction

    // result of each ALU function as the instruction set defines it
    function automatic logic [data_width-1:0] alu_model(input alu_func_e f,
            input logic [data_width-1:0] a, input logic [data_width-1:0] b);
        case (f)
            alu_add: return a + b;
            alu_sub: return a - b;
            alu_and: return a & b;
            alu_or:  return a | b;
            alu_xor: return a ^ b;
            alu_sll: return a << b[4:0];       // only five bits of shift amount count
            alu_srl: return a >> b[4:0];
            default: return ($signed(a) < $signed(b)) ? 'd1 : 'd0;  // signed set-less-than
        endcase
    endfunction

    // register 0, or the destination of one of the eight previous words
    function automatic logic [reg_addr_width-1:0] pick_src();
        int k;
        k = int'(rand_range(9));
        if (k == 0 || k > prog_n) begin
            return '0;
        end
        return reg_addr_width'(1 + (prog_n - k) % 31);
    endfunction

    task automatic make_word(input bit imm_only);
        insn_word_u  w;
        int unsigned hi;
        int unsigned lo;
        w  = '0;
        hi = rand_range(4);
        lo = rand_range(65536);
        if (imm_only || rand_range(2) == 1) begin
            w.i.is_imm = 1'b1;
            w.i.src1   = imm_only ? '0 : pick_src();
            w.i.imm    = {hi[1:0], lo[15:0]};
        end else begin
            w.r.src1 = pick_src();
            w.r.src2 = pick_src();
        end
        // func and dst sit at the same bits in both layouts
        w.r.func = imm_only ? alu_func_e'(3'(made % 8)) : alu_func_e'(3'(rand_range(8)));
        w.r.dst  = reg_addr_width'(1 + prog_n % 31);
        in_word  = w;
        in_valid = 1'b1;
        made++;
        prog_n++;
    endtask

    // acceptance order is program order, so the model runs in step with the handshake
    task automatic commit_word();
        logic [data_width-1:0] a;
        logic [data_width-1:0] b;
        logic [data_width-1:0] v;
        a = model_rf[in_word.r.src1];
        if (in_word.r.is_imm) begin
            // field value, minus 2^18 when its top bit marks it negative
            b = data_width'(in_word.i.imm);
            if (in_word.i.imm[imm_width-1]) begin
                b = b - (data_width'(1) << imm_width);
            end
        end else begin
            b = model_rf[in_word.r.src2];
        end
        v = alu_model(in_word.r.func, a, b);
        model_rf[in_word.r.dst] = v;
        exp_val[in_word.r.dst]  = v;
        exp_pend[in_word.r.dst] = 1'b1;
        sent++;
    endtask

    task automatic check_result(input logic [reg_addr_width-1:0] dst,
            input logic [data_width-1:0] value);
        if (!exp_pend[dst]) begin
            errors++;  // lost ordering or a duplicate result
            $display("a result for register %0d arrived with no instruction pending", dst);
        end else begin
            exp_pend[dst] = 1'b0;
            if (value !== exp_val[dst]) begin
                errors++;
                $display("Fail out_value for out_dst %h: got %h, expected %h",
                         dst, value, exp_val[dst]);
            end
        end
    endtask

    task automatic check_count(input string name, input int got, input int want);
        if (got != want) begin
            errors++;
            $display("Fail %s count: got %h, expected %h", name, got, want);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic want);
        if (got !== want) begin
            errors++;
            $display("Fail %s: got %h, expected %h", name, got, want);
        end
    endtask

    // one cycle at the falling edge, both handshakes complete on the next rising edge
    task automatic step(input logic rdy, input bit imm_only);
        out_ready = rdy;
        if (out_valid && rdy) begin
            check_result(out_dst, out_value);
            received++;
        end
        if (taken) begin
            in_valid = 1'b0;
            taken    = 1'b0;
        end
        if (!in_valid && made < word_limit) begin
            make_word(imm_only);
        end
        if (in_valid && in_ready) begin   // in_ready comes from registers, stable here
            commit_word();
            taken = 1'b1;
        end
    endtask

    task automatic run_test(input string name, input int count, input bit imm_only,
            input int ready_pct, input int hold);
        int err_start;
        err_start  = errors;
        sent       = 0;
        received   = 0;
        made       = 0;
        word_limit = count;
        repeat (hold) begin
            @(negedge clk);
            step(1'b0, imm_only);   // words pile up behind the blocked result port
        end
        if (hold > 0) begin
            if (sent > 7) begin
                errors++;
                $display("%0d words accepted with the result port blocked, at most 7 fit", sent);
            end
            word_limit = made;  // no new words, the last one offered still goes in
        end
        while (made < word_limit || in_valid || received < sent) begin
            @(negedge clk);
            step(rand_range(100) < ready_pct, imm_only);
        end
        // the port stays open a pipeline depth longer so a surplus result enters the count
        repeat (8) begin
            @(negedge clk);
            step(1'b1, imm_only);
        end
        check_count("result", received, sent);
        $display("test %s: %0d words, %0d results, %0d errors",
                 name, sent, received, errors - err_start);
    endtask

    initial begin
        reset       = 1'b1;
        in_valid    = 1'b0;
        in_word     = '0;
        out_ready   = 1'b0;
        rng         = 32'd14;
        errors      = 0;
        prog_n      = 0;
        taken       = 1'b0;
        cycles      = 0;
        cycle_limit = 200 * (40 + 200 + 200 + 64) + 1000;  // word caps of all tests
        for (int r = 0; r < reg_num; r++) begin
            model_rf[r] = '0;
            exp_val[r]  = '0;
            exp_pend[r] = 1'b0;
        end
        repeat (16) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        repeat (10) begin
            @(negedge clk);
            check_bit("in_ready", in_ready, 1'b1);
            check_bit("out_valid", out_valid, 1'b0);
        end
        $display("test after reset: 10 idle cycles, %0d errors", errors);
        run_test("immediate form", 40, 1'b1, 100, 0);
        run_test("dependent chains", 200, 1'b0, 100, 0);
        run_test("back-pressure", 200, 1'b0, 30, 0);
        run_test("full queue", 64, 1'b0, 100, 30);
        $display("5 tests, %0d errors", errors);
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > cycle_limit) begin
            $display("timeout after %0d cycles, the DUT stopped responding", cycles);
            $display("Finished with errors");
            $finish;
        end
    end

endmodule

//--- all.f
source/ooo_pkg.sv
source/insn_decoder.sv
source/issue_queue.sv
source/execute_stage.sv
source/ooo_alu_top.sv
tests/ooo_alu_properties.sv
tests/ooo_alu_tb.sv

//--- run.sh
#!/usr/bin/env bash
# build the testbench with Verilator, run it and judge the log
cd "$(dirname "$0")" || exit 1

verilator --binary --assert -Wno-fatal --top-module ooo_alu_tb -f all.f -o ooo_alu_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/ooo_alu_sim > sim.log 2>&1
sim_status=$?
cat sim.log
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if grep -q "Finished with errors" sim.log; then
    exit 1
fi
if ! grep -q "Finished with no errors" sim.log; then
    echo "simulation ended without a result line"
    exit 1
fi
exit 0
